// File: pgm_mem_params.svh
`ifndef PGM_MEM_PARAMS_SVH
`define PGM_MEM_PARAMS_SVH

// DDRAM side, 64-bit word addressed
`define PGM_DDRAM_AW   29  // Word address bits
`define PGM_DDRAM_DW   64  // Data bits per word
`define PGM_DDRAM_BEW  8   // One enable per byte

// Main CPU fetch port
`define PGM_CPU_AW     23  // CPU address bits 23..1, word granular

// ROM loader port
`define PGM_IOCTL_AW   27  // Loader byte address
`define PGM_IOCTL_DW   16  // Loader data, one 16-bit lane

// Loader index carrying the ROM image to DDRAM
`define PGM_ROM_INDEX  0

`endif

// File: pgm_mem_pkg.sv
`default_nettype none

`include "pgm_mem_params.svh"

package pgm_mem_pkg;

    // DDRAM bus
    typedef logic [`PGM_DDRAM_AW-1:0]  ddram_addr_t;
    typedef logic [`PGM_DDRAM_DW-1:0]  ddram_data_t;
    typedef logic [`PGM_DDRAM_BEW-1:0] ddram_be_t;

    // CPU fetch port, one word is a quarter of a DDRAM word
    typedef logic [`PGM_CPU_AW-1:0]     cpu_addr_t;
    typedef logic [`PGM_DDRAM_DW/4-1:0] cpu_word_t;

    // Loader
    typedef logic [`PGM_IOCTL_AW-1:0] ioctl_addr_t;
    typedef logic [7:0]               ioctl_index_t;

    // Arbiter state, doubles as the tag of a finished read
    typedef enum logic [1:0] {
        slot_idle,
        slot_cpu,
        slot_video,
        slot_audio
    } arb_slot_t;

endpackage

`default_nettype wire

// File: pgm_req_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "pgm_mem_params.svh"

module pgm_req_decode (
    input  wire                   fixed_50m_clk,
    input  wire                   reset,
    input  wire                   cpu_req,    // Level, held until cpu_ack
    input  wire                   vid_rd,     // Level, held until vid_ack
    input  wire                   sound_rd,   // One fetch per rising edge
    input  wire                   cpu_ack,
    input  wire                   vid_ack,
    output pgm_mem_pkg::arb_slot_t next_slot  // Slot offered to the arbiter
);
    import pgm_mem_pkg::*;

    logic cpu_req_q;      // Registered request levels
    logic vid_rd_q;
    logic sound_rd_q;
    logic sound_rd_last;  // Previous audio level for edge detect

    always_ff @(posedge fixed_50m_clk) begin
        if (reset) begin
            cpu_req_q     <= 1'b0;
            vid_rd_q      <= 1'b0;
            sound_rd_q    <= 1'b0;
            sound_rd_last <= 1'b0;
        end else begin
            cpu_req_q     <= cpu_req;
            vid_rd_q      <= vid_rd;
            sound_rd_q    <= sound_rd;
            sound_rd_last <= sound_rd_q;  // Held level blocks a repeat fetch
        end
    end

    // Fixed priority, CPU > video > audio
    always_comb begin
        if (cpu_req_q && !cpu_ack) begin
            next_slot = slot_cpu;
        end else if (vid_rd_q && !vid_ack) begin  // Acked requests wait for drop
            next_slot = slot_video;
        end else if (sound_rd_q && !sound_rd_last) begin
            next_slot = slot_audio;               // Rising edge only
        end else begin
            next_slot = slot_idle;
        end
    end

endmodule

`default_nettype wire

// File: pgm_ddram_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "pgm_mem_params.svh"

module pgm_ddram_arbiter (
    input  wire                     fixed_50m_clk,
    input  wire                     reset,
    input  wire                     ioctl_download,
    input  pgm_mem_pkg::arb_slot_t   next_slot,
    input  pgm_mem_pkg::cpu_addr_t   cpu_addr,
    input  pgm_mem_pkg::ddram_addr_t vid_addr,
    input  pgm_mem_pkg::ddram_addr_t sound_addr,
    input  pgm_mem_pkg::ddram_addr_t wr_addr,     // Latched loader address
    input  wire                     wr_pending,
    input  wire                     ddram_busy,
    input  wire                     ddram_dout_ready,
    output logic                    ddram_rd,
    output pgm_mem_pkg::ddram_addr_t ddram_addr,
    output logic                    done,        // One-cycle pulse with read data valid
    output pgm_mem_pkg::arb_slot_t   done_slot
);
    import pgm_mem_pkg::*;

    localparam int CPU_PAD = `PGM_DDRAM_AW - `PGM_CPU_AW + 2;  // Zero bits above CPU word

    arb_slot_t state;
    logic      rd_issued;  // Read already sent in this slot
    logic      in_slot;

    assign in_slot = (state != slot_idle);

    // One read pulse per slot while no download runs
    assign ddram_rd = in_slot && !rd_issued && !ddram_busy && !ioctl_download;

    // Completion only counts after our own read went out
    assign done      = in_slot && rd_issued && ddram_dout_ready && !ioctl_download;
    assign done_slot = state;

    always_ff @(posedge fixed_50m_clk) begin
        if (reset) begin
            state     <= slot_idle;
            rd_issued <= 1'b0;
        end else if (ioctl_download) begin
            state     <= slot_idle;  // Loader owns DDRAM
            rd_issued <= 1'b0;
        end else begin
            case (state)
                slot_idle: begin
                    rd_issued <= 1'b0;
                    state     <= next_slot;  // Stays idle when nothing eligible
                end
                default: begin
                    if (ddram_rd) rd_issued <= 1'b1;
                    if (done) state <= slot_idle;  // Slot ends on read data
                end
            endcase
        end
    end

    // Address mux with the loader ahead of the slots
    always_comb begin
        if (ioctl_download || wr_pending) begin
            ddram_addr = wr_addr;
        end else if (state == slot_cpu) begin
            ddram_addr = {{CPU_PAD{1'b0}}, cpu_addr[`PGM_CPU_AW-1:2]};  // 4 CPU words per DDRAM word
        end else if (state == slot_audio) begin
            ddram_addr = sound_addr;
        end else begin
            ddram_addr = vid_addr;  // Video and idle
        end
    end

endmodule

`default_nettype wire

// File: pgm_read_return.sv
`timescale 1ns/1ps
`default_nettype none

`include "pgm_mem_params.svh"

module pgm_read_return (
    input  wire                     fixed_50m_clk,
    input  wire                     reset,
    input  wire                     done,
    input  pgm_mem_pkg::arb_slot_t   done_slot,
    input  pgm_mem_pkg::ddram_data_t ddram_dout,
    input  pgm_mem_pkg::cpu_addr_t   cpu_addr,
    input  wire                     cpu_req,
    input  wire                     vid_rd,
    input  wire                     sound_rd,
    output pgm_mem_pkg::cpu_word_t   cpu_data,
    output logic                    cpu_ack,
    output logic                    vid_ack,
    output logic                    sound_ack
);
    import pgm_mem_pkg::*;

    localparam int LANE_W = `PGM_DDRAM_DW / 4;

    ddram_data_t rd_buf;  // Last word fetched for the CPU
    cpu_word_t   lane;

    // Word capture on CPU completion
    always_ff @(posedge fixed_50m_clk) begin
        if (done && (done_slot == slot_cpu)) rd_buf <= ddram_dout;
    end

    // Lane picked by CPU address bits 2..1
    assign lane     = rd_buf[cpu_addr[1:0]*LANE_W +: LANE_W];
    assign cpu_data = {lane[7:0], lane[15:8]};  // Byte swap for big-endian 68000

    // Each ack set by its own completion and cleared by a low request
    always_ff @(posedge fixed_50m_clk) begin
        if (reset) begin
            cpu_ack   <= 1'b0;
            vid_ack   <= 1'b0;
            sound_ack <= 1'b0;
        end else begin
            if (done && (done_slot == slot_cpu)) begin
                cpu_ack <= 1'b1;
            end else if (!cpu_req) begin
                cpu_ack <= 1'b0;
            end

            if (done && (done_slot == slot_video)) begin
                vid_ack <= 1'b1;
            end else if (!vid_rd) begin
                vid_ack <= 1'b0;
            end

            if (done && (done_slot == slot_audio)) begin
                sound_ack <= 1'b1;
            end else if (!sound_rd) begin
                sound_ack <= 1'b0;  // Held for the whole sound_rd level
            end
        end
    end

endmodule

`default_nettype wire

// File: pgm_loader_write.sv
`timescale 1ns/1ps
`default_nettype none

`include "pgm_mem_params.svh"

module pgm_loader_write (
    input  wire                      fixed_50m_clk,
    input  wire                      reset,
    input  wire                      ioctl_download,
    input  wire                      ioctl_wr,
    input  pgm_mem_pkg::ioctl_addr_t  ioctl_addr,
    input  wire [`PGM_IOCTL_DW-1:0]  ioctl_dout,
    input  pgm_mem_pkg::ioctl_index_t ioctl_index,
    input  wire                      ddram_busy,
    output logic                     wr_pending,  // Also the DDRAM write strobe
    output pgm_mem_pkg::ddram_addr_t  wr_addr,
    output pgm_mem_pkg::ddram_data_t  ddram_din,
    output pgm_mem_pkg::ddram_be_t    ddram_be,
    output logic                     ioctl_wait
);
    localparam int ADDR_PAD = `PGM_DDRAM_AW - (`PGM_IOCTL_AW - 3);

    logic                     wr_take;  // Accept this loader write
    logic [`PGM_DDRAM_BEW-1:0] wr_be;

    assign wr_take = ioctl_download && ioctl_wr && (ioctl_index == `PGM_ROM_INDEX) && !wr_pending;

    always_ff @(posedge fixed_50m_clk) begin
        if (reset || !ioctl_download) begin
            wr_pending <= 1'b0;  // Abort on end of download
        end else if (wr_take) begin
            wr_pending <= 1'b1;
        end else if (wr_pending && !ddram_busy) begin
            wr_pending <= 1'b0;  // DDRAM took it this edge
        end
    end

    // Write payload, stable while pending
    always_ff @(posedge fixed_50m_clk) begin
        if (wr_take) begin
            wr_addr   <= {{ADDR_PAD{1'b0}}, ioctl_addr[`PGM_IOCTL_AW-1:3]};  // Byte addr / 8
            ddram_din <= {4{ioctl_dout}};  // Same word in every lane
            case (ioctl_addr[2:1])        // Enable only the addressed lane
                2'd0:    wr_be <= 8'h03;
                2'd1:    wr_be <= 8'h0C;
                2'd2:    wr_be <= 8'h30;
                default: wr_be <= 8'hC0;
            endcase
        end
    end

    assign ddram_be   = wr_pending ? wr_be : '1;  // Full word for reads
    assign ioctl_wait = wr_pending;               // Stall loader until write lands

endmodule

`default_nettype wire

// File: pgm_mem_hub.sv
`timescale 1ns/1ps
`default_nettype none

`include "pgm_mem_params.svh"

module pgm_mem_hub (
    input  wire                      fixed_50m_clk,
    input  wire                      reset,
    // ROM loader
    input  wire                      ioctl_download,
    input  wire                      ioctl_wr,
    input  pgm_mem_pkg::ioctl_addr_t  ioctl_addr,
    input  wire [`PGM_IOCTL_DW-1:0]  ioctl_dout,
    input  pgm_mem_pkg::ioctl_index_t ioctl_index,
    output logic                     ioctl_wait,
    // Main CPU ROM fetch
    input  wire                      cpu_req,
    input  pgm_mem_pkg::cpu_addr_t    cpu_addr,
    output pgm_mem_pkg::cpu_word_t    cpu_data,
    output logic                     cpu_ack,
    // Video tile fetch
    input  wire                      vid_rd,
    input  pgm_mem_pkg::ddram_addr_t  vid_addr,
    output logic                     vid_ack,
    // Sound sample fetch
    input  wire                      sound_rd,
    input  pgm_mem_pkg::ddram_addr_t  sound_addr,
    output logic                     sound_ack,
    // DDRAM
    output logic                     ddram_rd,
    output logic                     ddram_we,
    output pgm_mem_pkg::ddram_addr_t  ddram_addr,
    output pgm_mem_pkg::ddram_data_t  ddram_din,
    output pgm_mem_pkg::ddram_be_t    ddram_be,
    input  pgm_mem_pkg::ddram_data_t  ddram_dout,
    input  wire                      ddram_busy,
    input  wire                      ddram_dout_ready
);
    import pgm_mem_pkg::*;

    arb_slot_t   next_slot;   // Decode to arbiter
    arb_slot_t   done_slot;
    logic        done;        // Arbiter to read return
    ddram_addr_t wr_addr;     // Loader to arbiter mux
    logic        wr_pending;

    assign ddram_we = wr_pending;

    // Request decode
    pgm_req_decode u_decode (
        .fixed_50m_clk (fixed_50m_clk),
        .reset         (reset),
        .cpu_req       (cpu_req),
        .vid_rd        (vid_rd),
        .sound_rd      (sound_rd),
        .cpu_ack       (cpu_ack),  // Fed back to block re-fetch
        .vid_ack       (vid_ack),
        .next_slot     (next_slot)
    );

    // Slot sequencing and address mux
    pgm_ddram_arbiter u_arbiter (
        .fixed_50m_clk    (fixed_50m_clk),
        .reset            (reset),
        .ioctl_download   (ioctl_download),
        .next_slot        (next_slot),
        .cpu_addr         (cpu_addr),
        .vid_addr         (vid_addr),
        .sound_addr       (sound_addr),
        .wr_addr          (wr_addr),
        .wr_pending       (wr_pending),
        .ddram_busy       (ddram_busy),
        .ddram_dout_ready (ddram_dout_ready),
        .ddram_rd         (ddram_rd),
        .ddram_addr       (ddram_addr),
        .done             (done),
        .done_slot        (done_slot)
    );

    // Read data and acknowledges
    pgm_read_return u_return (
        .fixed_50m_clk (fixed_50m_clk),
        .reset         (reset),
        .done          (done),
        .done_slot     (done_slot),
        .ddram_dout    (ddram_dout),
        .cpu_addr      (cpu_addr),
        .cpu_req       (cpu_req),
        .vid_rd        (vid_rd),
        .sound_rd      (sound_rd),
        .cpu_data      (cpu_data),
        .cpu_ack       (cpu_ack),
        .vid_ack       (vid_ack),
        .sound_ack     (sound_ack)
    );

    // ROM download path
    pgm_loader_write u_loader (
        .fixed_50m_clk  (fixed_50m_clk),
        .reset          (reset),
        .ioctl_download (ioctl_download),
        .ioctl_wr       (ioctl_wr),
        .ioctl_addr     (ioctl_addr),
        .ioctl_dout     (ioctl_dout),
        .ioctl_index    (ioctl_index),
        .ddram_busy     (ddram_busy),
        .wr_pending     (wr_pending),
        .wr_addr        (wr_addr),
        .ddram_din      (ddram_din),
        .ddram_be       (ddram_be),
        .ioctl_wait     (ioctl_wait)
    );

endmodule

`default_nettype wire

// File: tb_ddram_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "pgm_mem_params.svh"

module tb_ddram_model (
    input  wire                      fixed_50m_clk,
    input  wire                      reset,
    input  wire                      ddram_rd,
    input  wire                      ddram_we,
    input  pgm_mem_pkg::ddram_addr_t  ddram_addr,
    input  pgm_mem_pkg::ddram_data_t  ddram_din,
    input  pgm_mem_pkg::ddram_be_t    ddram_be,
    output logic                     ddram_busy,
    output pgm_mem_pkg::ddram_data_t  ddram_dout,
    output logic                     ddram_dout_ready,
    output int                       wr_count,      // Writes accepted so far
    output pgm_mem_pkg::ddram_addr_t  wr_last_addr,  // Newest entry of the write log
    output pgm_mem_pkg::ddram_data_t  wr_last_din,
    output pgm_mem_pkg::ddram_be_t    wr_last_be
);
    import pgm_mem_pkg::*;

    int          rd_wait;  // Cycles left until read data, 0 when no read is open
    ddram_addr_t rd_addr;

    always @(posedge fixed_50m_clk) begin
        if (reset) begin
            ddram_busy       <= 1'b0;
            ddram_dout       <= '0;
            ddram_dout_ready <= 1'b0;
            rd_wait          <= 0;
            wr_count         <= 0;
        end else begin
            ddram_busy       <= ($urandom % 4) == 0;  // Busy about one cycle in four
            ddram_dout_ready <= 1'b0;
            if (ddram_rd) begin
                rd_wait <= 2 + int'($urandom % 5);   // 2 to 6 cycles of latency
                rd_addr <= ddram_addr;
            end else if (rd_wait == 1) begin
                ddram_dout_ready <= 1'b1;
                // Lane k holds address bits 13..0 then k
                ddram_dout <= {rd_addr[13:0], 2'd3, rd_addr[13:0], 2'd2,
                               rd_addr[13:0], 2'd1, rd_addr[13:0], 2'd0};
                rd_wait    <= 0;
            end else if (rd_wait > 1) begin
                rd_wait <= rd_wait - 1;
            end
            if (ddram_we && !ddram_busy) begin  // Write lands on a free cycle
                wr_count     <= wr_count + 1;
                wr_last_addr <= ddram_addr;
                wr_last_din  <= ddram_din;
                wr_last_be   <= ddram_be;
            end
        end
    end

endmodule

`default_nettype wire

// File: tb_pgm_mem_hub.sv
`timescale 1ns/1ps
`default_nettype none

`include "pgm_mem_params.svh"

module tb_pgm_mem_hub;
    import pgm_mem_pkg::*;

    localparam int ROWS    = 10;
    localparam int TIMEOUT = 200;  // Cycles allowed per wait
    localparam int K_CPU = 0, K_VID = 1, K_AUD = 2, K_PAIR = 3, K_LOAD = 4;
    localparam int SIG_CPU_ACK = 0, SIG_VID_ACK = 1, SIG_SND_ACK = 2, SIG_WAIT = 3;

    logic fixed_50m_clk, reset, ioctl_download, ioctl_wr, cpu_req, vid_rd, sound_rd;
    logic ioctl_wait, cpu_ack, vid_ack, sound_ack, ddram_rd, ddram_we;
    logic ddram_busy, ddram_dout_ready;
    logic [`PGM_IOCTL_DW-1:0] ioctl_dout;
    ioctl_addr_t  ioctl_addr;
    ioctl_index_t ioctl_index;
    cpu_addr_t    cpu_addr;
    cpu_word_t    cpu_data;
    ddram_addr_t  vid_addr, sound_addr, ddram_addr, wr_last_addr;
    ddram_data_t  ddram_din, ddram_dout, wr_last_din;
    ddram_be_t    ddram_be, wr_last_be;
    int           wr_count;

    int          errors;
    bit          timed_out;
    ddram_addr_t rd_log [$];  // Address of every ddram_rd pulse

    // Stimulus table where a is the main address and b the video address of a pair
    int           tbl_kind [ROWS] = '{K_CPU, K_CPU, K_VID, K_AUD, K_PAIR,
                                      K_AUD, K_LOAD, K_LOAD, K_LOAD, K_CPU};
    logic [31:0]  tbl_a [ROWS] = '{32'h0012345, 32'h0000ABE, 32'h00ABCDE, 32'h1234567,
                                   32'h07FFFF0, 32'h0FEDCBA, 32'h0001236, 32'h00000A2,
                                   32'h4000004, 32'h0000003};
    logic [31:0]  tbl_b [ROWS] = '{0, 0, 0, 0, 32'h0000777, 0, 0, 0, 0, 0};
    logic [15:0]  tbl_d [ROWS] = '{0, 0, 0, 0, 0, 0, 16'hBEEF, 16'h1234, 16'hA55A, 0};
    ioctl_index_t tbl_idx [ROWS] = '{0, 0, 0, 0, 0, 0, 8'd0, 8'd1, 8'd0, 0};

    pgm_mem_hub dut0 (.*);
    tb_ddram_model mem0 (.*);

    initial begin
        fixed_50m_clk = 1'b0;
        forever #10 fixed_50m_clk = ~fixed_50m_clk;  // 50 MHz
    end

    always @(posedge fixed_50m_clk) begin
        if (ddram_rd) rd_log.push_back(ddram_addr);
    end

    // Expected values from the memory map
    function automatic ddram_addr_t cpu_word_addr(input cpu_addr_t a);
        return ddram_addr_t'(a >> 2);  // Four CPU words per DDRAM word
    endfunction

    function automatic cpu_word_t cpu_expect(input cpu_addr_t a);
        ddram_addr_t w;
        cpu_word_t   l;
        w = cpu_word_addr(a);
        l = {w[13:0], a[1:0]};
        return {l[7:0], l[15:8]};  // Big-endian view of the lane
    endfunction

    function automatic ddram_be_t lane_be(input logic [1:0] k);
        return 8'h03 << {k, 1'b0};
    endfunction

    function automatic logic pick(input int sig);
        case (sig)
            SIG_CPU_ACK: return cpu_ack;
            SIG_VID_ACK: return vid_ack;
            SIG_SND_ACK: return sound_ack;
            default:     return ioctl_wait;
        endcase
    endfunction

    task automatic check_word(input string name, input cpu_word_t got, input cpu_word_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input ddram_addr_t got, input ddram_addr_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_be(input string name, input ddram_be_t got, input ddram_be_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    // Polls one status output on falling edges
    task automatic wait_level(input int sig, input logic level, input string name);
        int n;
        n = 0;
        do begin
            @(negedge fixed_50m_clk);
            n++;
        end while (pick(sig) !== level && n < TIMEOUT);
        if (pick(sig) !== level) begin
            $display("Timeout at %0t: %s never went to %b", $time, name, level);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic expect_reads(input int base, input int n, input string what);
        if (rd_log.size() - base != n) begin
            $display("At %0t the %s saw %0d ddram_rd pulses instead of %0d",
                     $time, what, rd_log.size() - base, n);
            errors++;
        end
    endtask

    task automatic check_quiet();
        check_bit("ddram_rd", ddram_rd, 1'b0);
        check_bit("ddram_we", ddram_we, 1'b0);
        check_bit("ioctl_wait", ioctl_wait, 1'b0);
        check_bit("cpu_ack", cpu_ack, 1'b0);
        check_bit("vid_ack", vid_ack, 1'b0);
        check_bit("sound_ack", sound_ack, 1'b0);
        check_be("ddram_be", ddram_be, '1);  // Full word when no write waits
    endtask

    task automatic read_cpu(input cpu_addr_t a);
        int n0;
        n0 = rd_log.size();
        @(posedge fixed_50m_clk);
        cpu_addr <= a;
        cpu_req  <= 1'b1;
        wait_level(SIG_CPU_ACK, 1'b1, "cpu_ack");
        expect_reads(n0, 1, "CPU read");
        if (rd_log.size() > n0) check_addr("ddram_addr", rd_log[n0], cpu_word_addr(a));
        check_word("cpu_data", cpu_data, cpu_expect(a));
        repeat (5) begin  // Held request keeps the ack and fetches nothing new
            @(negedge fixed_50m_clk);
            check_bit("cpu_ack", cpu_ack, 1'b1);
        end
        expect_reads(n0, 1, "held CPU request");
        @(posedge fixed_50m_clk);
        cpu_req <= 1'b0;
        wait_level(SIG_CPU_ACK, 1'b0, "cpu_ack");
    endtask

    task automatic read_video(input ddram_addr_t a);
        int n0;
        n0 = rd_log.size();
        @(posedge fixed_50m_clk);
        vid_addr <= a;
        vid_rd   <= 1'b1;
        wait_level(SIG_VID_ACK, 1'b1, "vid_ack");
        expect_reads(n0, 1, "video read");
        if (rd_log.size() > n0) check_addr("ddram_addr", rd_log[n0], a);
        @(posedge fixed_50m_clk);
        vid_rd <= 1'b0;
        wait_level(SIG_VID_ACK, 1'b0, "vid_ack");
    endtask

    task automatic read_audio(input ddram_addr_t a);
        int n0;
        n0 = rd_log.size();
        @(posedge fixed_50m_clk);
        sound_addr <= a;
        sound_rd   <= 1'b1;
        wait_level(SIG_SND_ACK, 1'b1, "sound_ack");
        if (rd_log.size() > n0) check_addr("ddram_addr", rd_log[n0], a);
        repeat (8) begin
            @(negedge fixed_50m_clk);
            check_bit("sound_ack", sound_ack, 1'b1);
        end
        expect_reads(n0, 1, "held sound request");  // Only the edge fetches
        @(posedge fixed_50m_clk);
        sound_rd <= 1'b0;
        wait_level(SIG_SND_ACK, 1'b0, "sound_ack");
    endtask

    // CPU and video in the same cycle where the CPU goes first
    task automatic read_pair(input cpu_addr_t a, input ddram_addr_t b);
        int n0;
        n0 = rd_log.size();
        @(posedge fixed_50m_clk);
        cpu_addr <= a;
        vid_addr <= b;
        cpu_req  <= 1'b1;
        vid_rd   <= 1'b1;
        wait_level(SIG_CPU_ACK, 1'b1, "cpu_ack");
        check_word("cpu_data", cpu_data, cpu_expect(a));
        @(posedge fixed_50m_clk);
        cpu_req <= 1'b0;
        wait_level(SIG_VID_ACK, 1'b1, "vid_ack");
        expect_reads(n0, 2, "CPU and video pair");
        if (rd_log.size() > n0 + 1) begin
            check_addr("first ddram_addr", rd_log[n0], cpu_word_addr(a));
            check_addr("second ddram_addr", rd_log[n0 + 1], b);
        end
        @(posedge fixed_50m_clk);
        vid_rd <= 1'b0;
        wait_level(SIG_VID_ACK, 1'b0, "vid_ack");
        check_bit("cpu_ack", cpu_ack, 1'b0);
    endtask

    task automatic load_word(input ioctl_addr_t a, input cpu_word_t d, input ioctl_index_t idx);
        int n0;
        int w0;
        n0 = rd_log.size();
        w0 = wr_count;
        @(posedge fixed_50m_clk);
        ioctl_download <= 1'b1;
        ioctl_addr     <= a;
        ioctl_dout     <= d;
        ioctl_index    <= idx;
        ioctl_wr       <= 1'b1;
        vid_rd         <= 1'b1;  // Video request that the download must hold off
        @(posedge fixed_50m_clk);
        ioctl_wr <= 1'b0;
        if (idx == `PGM_ROM_INDEX) begin
            @(negedge fixed_50m_clk);  // Write latched and pending now
            check_bit("ioctl_wait", ioctl_wait, 1'b1);
            check_bit("ddram_we", ddram_we, 1'b1);
            check_addr("ddram_addr", ddram_addr, ddram_addr_t'(a >> 3));
            check_be("ddram_be", ddram_be, lane_be(a[2:1]));
            for (int k = 0; k < 4; k++) check_word("ddram_din lane", ddram_din[16*k +: 16], d);
            wait_level(SIG_WAIT, 1'b0, "ioctl_wait");
            if (wr_count != w0 + 1) begin
                $display("At %0t the DDRAM model logged %0d writes instead of one",
                         $time, wr_count - w0);
                errors++;
            end
            check_addr("logged write address", wr_last_addr, ddram_addr_t'(a >> 3));
            check_be("logged write enables", wr_last_be, lane_be(a[2:1]));
            for (int k = 0; k < 4; k++) begin
                check_word("logged write data lane", wr_last_din[16*k +: 16], d);
            end
        end else begin
            repeat (6) begin  // Other indexes never reach DDRAM
                @(negedge fixed_50m_clk);
                check_bit("ioctl_wait", ioctl_wait, 1'b0);
                check_bit("ddram_we", ddram_we, 1'b0);
            end
            if (wr_count != w0) begin
                $display("At %0t a write with index %0d reached DDRAM", $time, idx);
                errors++;
            end
        end
        expect_reads(n0, 0, "download");
        @(posedge fixed_50m_clk);
        ioctl_download <= 1'b0;
        wait_level(SIG_VID_ACK, 1'b1, "vid_ack");  // Held video read runs afterwards
        expect_reads(n0, 1, "video read after download");
        if (rd_log.size() > n0) check_addr("ddram_addr", rd_log[n0], vid_addr);
        @(posedge fixed_50m_clk);
        vid_rd <= 1'b0;
        wait_level(SIG_VID_ACK, 1'b0, "vid_ack");
    endtask

    initial begin
        void'($urandom(57));
        errors         = 0;
        timed_out      = 1'b0;
        reset          <= 1'b1;
        ioctl_download <= 1'b0;
        ioctl_wr       <= 1'b0;
        ioctl_addr     <= '0;
        ioctl_dout     <= '0;
        ioctl_index    <= '0;
        cpu_req        <= 1'b0;
        cpu_addr       <= '0;
        vid_rd         <= 1'b0;
        vid_addr       <= '0;
        sound_rd       <= 1'b0;
        sound_addr     <= '0;
        repeat (4) begin
            @(negedge fixed_50m_clk);
            check_quiet();
        end
        @(posedge fixed_50m_clk);
        reset <= 1'b0;  // Fifth edge in reset
        @(negedge fixed_50m_clk);
        check_quiet();
        for (int i = 0; i < ROWS && !timed_out; i++) begin
            case (tbl_kind[i])
                K_CPU:   read_cpu(cpu_addr_t'(tbl_a[i]));
                K_VID:   read_video(ddram_addr_t'(tbl_a[i]));
                K_AUD:   read_audio(ddram_addr_t'(tbl_a[i]));
                K_PAIR:  read_pair(cpu_addr_t'(tbl_a[i]), ddram_addr_t'(tbl_b[i]));
                default: load_word(ioctl_addr_t'(tbl_a[i]), tbl_d[i], tbl_idx[i]);
            endcase
        end
        repeat (4) @(negedge fixed_50m_clk);
        $display("Run complete with %0d error(s)", errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+.
pgm_mem_pkg.sv
pgm_req_decode.sv
pgm_ddram_arbiter.sv
pgm_read_return.sv
pgm_loader_write.sv
pgm_mem_hub.sv
tb_ddram_model.sv
tb_pgm_mem_hub.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the memory hub testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module tb_pgm_mem_hub -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "ERRORS FOUND" sim.log; then
    exit 1
fi
exit 0
